//--- testbench/md_tests.txt
# operator(0 MUL, 1 MULH, 2 DIV, 3 REM) signed_mode(bit0 a, bit1 b)
# op_a op_b expected, all hex
0 0 00000000 12345678 00000000
0 3 00000007 00000001 00000007
0 3 00000003 00000005 0000000f
0 3 ffffffff 00000002 fffffffe
0 0 12345678 00000010 23456780
0 3 fffffffd 00000007 ffffffeb
0 0 80000000 80000000 00000000
0 0 0000ffff 0000ffff fffe0001
0 3 7fffffff 7fffffff 00000001
0 3 00000005 ffffffff fffffffb
1 3 00000002 00000003 00000000
1 3 ffffffff ffffffff 00000000
1 3 ffffffff 00000001 ffffffff
1 3 80000000 80000000 40000000
1 3 80000000 00000002 ffffffff
1 3 7fffffff 7fffffff 3fffffff
1 0 ffffffff ffffffff fffffffe
1 0 80000000 00000002 00000001
1 0 12345678 00000000 00000000
1 1 ffffffff ffffffff ffffffff
1 1 00000002 ffffffff 00000001
1 1 80000000 ffffffff 80000000
2 3 00000014 00000006 00000003
2 3 ffffffec 00000006 fffffffd
2 3 00000014 fffffffa fffffffd
2 3 ffffffec fffffffa 00000003
2 0 ffffffff 00000002 7fffffff
2 0 80000000 00000003 2aaaaaaa
2 3 80000000 ffffffff 80000000
2 3 12345678 00000000 ffffffff
2 3 80000000 00000002 c0000000
2 0 00000064 0000000a 0000000a
3 3 00000014 00000006 00000002
3 3 ffffffec 00000006 fffffffe
3 3 00000014 fffffffa 00000002
3 3 ffffffec fffffffa fffffffe
3 0 ffffffff 00000002 00000001
3 0 80000000 00000003 00000002
3 3 80000000 ffffffff 00000000
3 3 12345678 00000000 12345678
3 0 87654321 00000000 87654321
3 3 80000000 00000003 fffffffe

//--- flist.f
rtl/md_pkg.sv
rtl/md_ctrl_if.sv
rtl/md_adder_if.sv
rtl/md_ctrl.sv
rtl/md_datapath.sv
rtl/md_adder.sv
rtl/md_slow_top.sv
testbench/tb_md_slow.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the multiply/divide testbench with Verilator.
# The exit status is the simulator's: nonzero when the testbench fails.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_md_slow \
	-f flist.f --Mdir obj_dir -o tb_md_slow; then
	echo "Verilator build failed"
	exit 1
fi

if [ ! -x obj_dir/tb_md_slow ]; then
	echo "Simulation binary is missing"
	exit 1
fi

./obj_dir/tb_md_slow
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit "$status"
fi

exit 0

//--- testbench/tb_md_slow.sv
// Testbench for the slow multiply/divide unit
// Replays the vectors of md_tests.txt with random stalls and idle gaps

`timescale 1ns/1ps
`default_nettype none

module tb_md_slow;

	localparam int unsigned VALID_TIMEOUT = 200;
	localparam int unsigned RESET_CYCLES  = 16;

	logic        clk;
	logic        rst_n;
	logic        mult_en;
	logic        div_en;
	logic [1:0]  operator;
	logic [1:0]  signed_mode;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] result;
	logic        valid;

	int unsigned pulse_count;
	int unsigned op_count;

	md_slow_top dut (
		.clk_i         (clk),
		.rst_ni        (rst_n),
		.mult_en_i     (mult_en),
		.div_en_i      (div_en),
		.operator_i    (operator),
		.signed_mode_i (signed_mode),
		.op_a_i        (op_a),
		.op_b_i        (op_b),
		.result_o      (result),
		.valid_o       (valid)
	);

	always #10 clk = ~clk;

	// Every cycle with valid high counts as one result
	always @(negedge clk) begin
		if (rst_n && valid) begin
			pulse_count = pulse_count + 1;
		end
	end

	task automatic check_value(input int unsigned index, input string what,
			input logic [31:0] actual, input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t: op %0d %s got %h, expected %h",
					$time, index, what, actual, expected);
			$display("Some tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic idle_gap(input int unsigned cycles, input int unsigned index);
		repeat (cycles) begin
			@(negedge clk);
			check_value(index, "valid while idle", 32'(valid), 32'h0);
		end
	endtask

	// ****************************************
	// One request, held until valid
	// ****************************************
	task automatic run_request(input int unsigned index, input logic [1:0] op,
			input logic [1:0] mode, input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] expected);
		int unsigned cycles;
		int unsigned stall_len;
		logic        is_div;
		logic        done;
		is_div = op[1];
		@(posedge clk);
		operator    <= op;
		signed_mode <= mode;
		op_a        <= a;
		op_b        <= b;
		mult_en     <= ~is_div;
		div_en      <= is_div;
		cycles = 0;
		done   = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (valid) begin
				done = 1'b1;
			end else begin
				cycles = cycles + 1;
				if (cycles > VALID_TIMEOUT) begin
					$display("Timeout: no valid_o within %0d cycles for op %0d",
							VALID_TIMEOUT, index);
					$display("Some tests failed");
					$fatal(1, "valid timeout");
				end
				// Pause the operation now and then
				if ($urandom_range(7, 0) == 0) begin
					stall_len = $urandom_range(4, 1);
					@(posedge clk);
					mult_en <= 1'b0;
					div_en  <= 1'b0;
					repeat (stall_len) begin
						@(negedge clk);
						check_value(index, "valid during stall", 32'(valid), 32'h0);
					end
					@(posedge clk);
					mult_en <= ~is_div;
					div_en  <= is_div;
				end
			end
		end
		check_value(index, "result", result, expected);
		@(posedge clk);
		mult_en <= 1'b0;
		div_en  <= 1'b0;
	endtask

	initial begin
		int          fd;
		int          fields;
		int          op_val;
		int          mode_val;
		int unsigned gap;
		string       line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] expected;
		clk         = 1'b0;
		rst_n       = 1'b0;
		mult_en     = 1'b0;
		div_en      = 1'b0;
		operator    = 2'd0;
		signed_mode = 2'd0;
		op_a        = 32'h0;
		op_b        = 32'h0;
		pulse_count = 0;
		op_count    = 0;
		void'($urandom(32'h9f61));

		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_value(0, "valid in reset", 32'(valid), 32'h0);
		end
		@(posedge clk);
		rst_n <= 1'b1;
		idle_gap(2, 0);

		fd = $fopen("testbench/md_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the vector file testbench/md_tests.txt");
			$display("Some tests failed");
			$fatal(1, "missing vector file");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Skip blank and comment lines
			if (line.len() < 2 || line.getc(0) == 8'h23) begin
				continue;
			end
			fields = $sscanf(line, "%d %d %h %h %h", op_val, mode_val, a, b, expected);
			if (fields != 5) begin
				$display("Malformed vector line after op %0d: %s", op_count, line);
				$display("Some tests failed");
				$fatal(1, "bad vector line");
			end
			gap = $urandom_range(3, 0);
			idle_gap(gap, op_count);
			run_request(op_count, 2'(op_val), 2'(mode_val), a, b, expected);
			op_count++;
		end
		$fclose(fd);

		idle_gap(2, op_count);
		check_value(op_count, "valid pulse count", pulse_count, op_count);
		if (op_count == 0) begin
			$display("No vectors were read from the vector file");
			$display("Some tests failed");
			$fatal(1, "empty vector file");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- rtl/md_slow_top.sv
// Slow multiply/divide unit for a 32-bit RISC-V core
// Start-and-hold requests on mult_en_i or div_en_i, result with valid_o

`timescale 1ns/1ps
`default_nettype none

module md_slow_top (
	input  logic        clk_i,
	input  logic        rst_ni,
	input  logic        mult_en_i,
	input  logic        div_en_i,
	input  logic [1:0]  operator_i,
	input  logic [1:0]  signed_mode_i,
	input  logic [31:0] op_a_i,
	input  logic [31:0] op_b_i,
	output logic [31:0] result_o,
	output logic        valid_o
);

	md_ctrl_if  ctrl_if ();
	md_adder_if add_if ();

	md_ctrl u_ctrl (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.mult_en_i  (mult_en_i),
		.div_en_i   (div_en_i),
		.operator_i (md_pkg::md_op_e'(operator_i)),
		.ctrl       (ctrl_if.ctrl),
		.valid_o    (valid_o)
	);

	md_datapath u_datapath (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.signed_mode_i (signed_mode_i),
		.op_a_i        (op_a_i),
		.op_b_i        (op_b_i),
		.div_en_i      (div_en_i),
		.ctrl          (ctrl_if.dp),
		.add           (add_if.dp),
		.result_o      (result_o)
	);

	md_adder u_adder (
		.op_a_i (op_a_i),
		.op_b_i (op_b_i),
		.ctrl   (ctrl_if.adder),
		.add    (add_if.adder)
	);

endmodule

`default_nettype wire

//--- rtl/md_adder.sv
// Shared adder of the multiply/divide unit
// Picks two 33-bit operands per operation and state, adds them to 34 bits.
// Division operands carry a low 1 in both so the carry-in comes for free

`timescale 1ns/1ps
`default_nettype none

module md_adder (
	input  md_pkg::data_t op_a_i,
	input  md_pkg::data_t op_b_i,
	md_ctrl_if.adder      ctrl,
	md_adder_if.adder     add
);

	md_pkg::ext_t opa;
	md_pkg::ext_t opb;
	md_pkg::ext_t pp;
	md_pkg::ext_t last_pp;
	logic [31:0]  b_mask;

	// ****************************************
	// Partial products
	// ****************************************
	assign b_mask  = {32{add.b_shift[0]}};
	assign pp      = {~(add.a_shift[32] & add.b_shift[0]), add.a_shift[31:0] & b_mask};
	// Sign row of a signed product is subtracted
	assign last_pp = {(add.a_shift[32] & add.b_shift[0]), ~(add.a_shift[31:0] & b_mask)};

	always_comb begin
		opa = add.accum;
		opb = pp;
		case (ctrl.op)
			md_pkg::MD_OP_MULL: begin
				opb = pp;
			end
			md_pkg::MD_OP_MULH: begin
				opb = (ctrl.state == md_pkg::MD_LAST) ? last_pp : pp;
			end
			default: begin
				case (ctrl.state)
					md_pkg::MD_ABS_A: begin
						opa = {32'h0, 1'b1};
						opb = {~op_a_i, 1'b1};
					end
					md_pkg::MD_ABS_B: begin
						opa = {32'h0, 1'b1};
						opb = {~op_b_i, 1'b1};
					end
					md_pkg::MD_CHANGE_SIGN: begin
						opa = {32'h0, 1'b1};
						opb = {~add.accum[31:0], 1'b1};
					end
					default: begin
						// Trial subtraction of the divisor
						opa = {add.accum[31:0], 1'b1};
						opb = {~add.b_shift[31:0], 1'b1};
					end
				endcase
			end
		endcase
	end

	assign add.sum_ext = md_pkg::add_t'(opa) + md_pkg::add_t'(opb);
	assign add.sum     = add.sum_ext[32:1];

endmodule

`default_nettype wire

//--- rtl/md_datapath.sv
// Datapath of the multiply/divide unit
// Accumulator window, operand shift registers and numerator,
// with sign handling and the restoring-division step

`timescale 1ns/1ps
`default_nettype none

module md_datapath (
	input  logic          clk_i,
	input  logic          rst_ni,
	input  logic [1:0]    signed_mode_i,
	input  md_pkg::data_t op_a_i,
	input  md_pkg::data_t op_b_i,
	input  logic          div_en_i,
	md_ctrl_if.dp         ctrl,
	md_adder_if.dp        add,
	output md_pkg::data_t result_o
);

	md_pkg::ext_t  accum_q;
	md_pkg::ext_t  accum_d;
	md_pkg::ext_t  a_shift_q;
	md_pkg::ext_t  a_shift_d;
	md_pkg::ext_t  b_shift_q;
	md_pkg::ext_t  b_shift_d;
	md_pkg::data_t numer_q;
	md_pkg::data_t numer_d;

	logic          sign_a;
	logic          sign_b;
	md_pkg::ext_t  a_ext;
	md_pkg::ext_t  b_ext;
	md_pkg::ext_t  res_l;
	md_pkg::ext_t  res_h;
	md_pkg::ext_t  one_shift;
	md_pkg::ext_t  next_rem;
	md_pkg::ext_t  next_quot;
	md_pkg::cnt_t  count_m1;
	logic          is_ge;

	assign sign_a = op_a_i[31] & signed_mode_i[0];
	assign sign_b = op_b_i[31] & signed_mode_i[1];
	assign a_ext  = {sign_a, op_a_i};
	assign b_ext  = {sign_b, op_b_i};

	assign res_l = add.sum_ext[32:0];
	assign res_h = add.sum_ext[33:1];

	// ****************************************
	// Division step
	// ****************************************
	assign count_m1  = ctrl.count - md_pkg::cnt_t'(1);
	assign one_shift = md_pkg::ext_t'(1) << ctrl.count;
	// Remainder window minus divisor did not go negative
	assign is_ge = ((accum_q[31] ^ b_shift_q[31]) == 1'b0) ? (res_h[31] == 1'b0) : accum_q[31];
	assign next_rem  = is_ge ? res_h : accum_q;
	assign next_quot = is_ge ? (a_shift_q | one_shift) : a_shift_q;

	// Status for the sequencer
	assign ctrl.b_rest_zero = (ctrl.state == md_pkg::MD_IDLE) ? (b_ext[32:1] == '0) :
			(b_shift_q[32:1] == '0);
	assign ctrl.divisor_zero = (op_b_i == '0);

	always_comb begin
		accum_d   = accum_q;
		a_shift_d = a_shift_q;
		b_shift_d = b_shift_q;
		numer_d   = numer_q;
		if (ctrl.en) begin
			case (ctrl.state)
				md_pkg::MD_IDLE: begin
					case (ctrl.op)
						md_pkg::MD_OP_MULL: begin
							a_shift_d = a_ext << 1;
							accum_d   = {~(a_ext[32] & op_b_i[0]), a_ext[31:0] & {32{op_b_i[0]}}};
							b_shift_d = b_ext >> 1;
						end
						md_pkg::MD_OP_MULH: begin
							a_shift_d = a_ext;
							accum_d   = {1'b1, ~(a_ext[32] & op_b_i[0]),
									a_ext[31:1] & {31{op_b_i[0]}}};
							b_shift_d = b_ext >> 1;
						end
						md_pkg::MD_OP_DIV: begin
							accum_d = '1;
						end
						default: begin
							accum_d = a_ext;
						end
					endcase
				end
				md_pkg::MD_ABS_A: begin
					a_shift_d = '0;
					numer_d   = sign_a ? add.sum : op_a_i;
				end
				md_pkg::MD_ABS_B: begin
					accum_d   = {32'h0, numer_q[31]};
					b_shift_d = sign_b ? {1'b0, add.sum} : {1'b0, op_b_i};
				end
				md_pkg::MD_COMP: begin
					case (ctrl.op)
						md_pkg::MD_OP_MULL: begin
							accum_d   = res_l;
							a_shift_d = a_shift_q << 1;
							b_shift_d = b_shift_q >> 1;
						end
						md_pkg::MD_OP_MULH: begin
							accum_d   = res_h;
							b_shift_d = b_shift_q >> 1;
						end
						default: begin
							// Shift in the next numerator bit
							accum_d   = {next_rem[31:0], numer_q[count_m1]};
							a_shift_d = next_quot;
						end
					endcase
				end
				md_pkg::MD_LAST: begin
					case (ctrl.op)
						md_pkg::MD_OP_DIV: accum_d = next_quot;
						md_pkg::MD_OP_REM: accum_d = {1'b0, next_rem[31:0]};
						default:           accum_d = res_l;
					endcase
				end
				md_pkg::MD_CHANGE_SIGN: begin
					if (ctrl.op == md_pkg::MD_OP_DIV) begin
						accum_d = (sign_a ^ sign_b) ? {1'b0, add.sum} : accum_q;
					end else begin
						// Remainder follows the dividend
						accum_d = sign_a ? {1'b0, add.sum} : accum_q;
					end
				end
				default: begin
					accum_d = accum_q;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			accum_q   <= '0;
			a_shift_q <= '0;
			b_shift_q <= '0;
			numer_q   <= '0;
		end else begin
			accum_q   <= accum_d;
			a_shift_q <= a_shift_d;
			b_shift_q <= b_shift_d;
			numer_q   <= numer_d;
		end
	end

	assign add.accum   = accum_q;
	assign add.a_shift = a_shift_q;
	assign add.b_shift = b_shift_q;

	assign result_o = div_en_i ? accum_q[31:0] : res_l[31:0];

endmodule

`default_nettype wire

//--- rtl/md_ctrl.sv
// Sequencer of the multiply/divide unit
// FSM and iteration counter; holds whenever both enables are low

`timescale 1ns/1ps
`default_nettype none

module md_ctrl (
	input  logic           clk_i,
	input  logic           rst_ni,
	input  logic           mult_en_i,
	input  logic           div_en_i,
	input  md_pkg::md_op_e operator_i,
	md_ctrl_if.ctrl        ctrl,
	output logic           valid_o
);

	md_pkg::md_state_e state_q;
	md_pkg::md_state_e state_d;
	md_pkg::cnt_t      count_q;
	md_pkg::cnt_t      count_d;
	logic              en;
	logic              is_mult;

	assign en = mult_en_i | div_en_i;
	assign is_mult = (operator_i == md_pkg::MD_OP_MULL) |
			(operator_i == md_pkg::MD_OP_MULH);

	assign ctrl.state = state_q;
	assign ctrl.count = count_q;
	assign ctrl.op    = operator_i;
	assign ctrl.en    = en;

	// ****************************************
	// Next state
	// ****************************************
	always_comb begin
		state_d = state_q;
		count_d = count_q;
		if (en) begin
			case (state_q)
				md_pkg::MD_IDLE: begin
					count_d = md_pkg::CNT_START;
					case (operator_i)
						md_pkg::MD_OP_MULL: begin
							state_d = ctrl.b_rest_zero ? md_pkg::MD_LAST : md_pkg::MD_COMP;
						end
						md_pkg::MD_OP_MULH: begin
							state_d = md_pkg::MD_COMP;
						end
						default: begin
							// Zero divisor result is already in place
							state_d = ctrl.divisor_zero ? md_pkg::MD_FINISH : md_pkg::MD_ABS_A;
						end
					endcase
				end
				md_pkg::MD_ABS_A: begin
					state_d = md_pkg::MD_ABS_B;
				end
				md_pkg::MD_ABS_B: begin
					state_d = md_pkg::MD_COMP;
				end
				md_pkg::MD_COMP: begin
					count_d = count_q - md_pkg::cnt_t'(1);
					// Early out once no multiplier bits remain
					if ((count_q == md_pkg::cnt_t'(1)) ||
							((operator_i == md_pkg::MD_OP_MULL) && ctrl.b_rest_zero)) begin
						state_d = md_pkg::MD_LAST;
					end else begin
						state_d = md_pkg::MD_COMP;
					end
				end
				md_pkg::MD_LAST: begin
					state_d = is_mult ? md_pkg::MD_IDLE : md_pkg::MD_CHANGE_SIGN;
				end
				md_pkg::MD_CHANGE_SIGN: begin
					state_d = md_pkg::MD_FINISH;
				end
				md_pkg::MD_FINISH: begin
					state_d = md_pkg::MD_IDLE;
				end
				default: begin
					state_d = md_pkg::MD_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= md_pkg::MD_IDLE;
			count_q <= '0;
		end else begin
			state_q <= state_d;
			count_q <= count_d;
		end
	end

	// Multiplies finish in the last step, divides one state later
	assign valid_o = en & ((state_q == md_pkg::MD_FINISH) |
			((state_q == md_pkg::MD_LAST) & is_mult));

endmodule

`default_nettype wire

//--- rtl/md_adder_if.sv
// Adder bundle of the multiply/divide unit
// Datapath registers to the adder, sums back

`timescale 1ns/1ps
`default_nettype none

interface md_adder_if;

	md_pkg::ext_t  accum;
	md_pkg::ext_t  a_shift;
	md_pkg::ext_t  b_shift;
	md_pkg::add_t  sum_ext;
	md_pkg::data_t sum;

	modport dp (
		output accum, a_shift, b_shift,
		input  sum_ext, sum
	);

	modport adder (
		input  accum, a_shift, b_shift,
		output sum_ext, sum
	);

endinterface

`default_nettype wire

//--- rtl/md_ctrl_if.sv
// Control bundle of the multiply/divide unit
// Sequencer state and counter out, datapath status back

`timescale 1ns/1ps
`default_nettype none

interface md_ctrl_if;

	md_pkg::md_state_e state;
	md_pkg::cnt_t      count;
	md_pkg::md_op_e    op;
	logic              en;
	logic              b_rest_zero;
	logic              divisor_zero;

	modport ctrl (
		output state, count, op, en,
		input  b_rest_zero, divisor_zero
	);

	modport dp (
		input  state, count, op, en,
		output b_rest_zero, divisor_zero
	);

	// Adder only needs to know what to add
	modport adder (
		input state, op
	);

endinterface

`default_nettype wire

//--- rtl/md_pkg.sv
// Shared definitions for the bit-serial multiply/divide unit
// Widths, operation codes, FSM states and data types

`default_nettype none

package md_pkg;

	// ****************************************
	// Widths
	// ****************************************
	localparam int unsigned DATA_W = 32;
	localparam int unsigned EXT_W  = DATA_W + 1;
	localparam int unsigned ADD_W  = DATA_W + 2;
	localparam int unsigned CNT_W  = 5;

	// ****************************************
	// Types
	// ****************************************
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [EXT_W-1:0]  ext_t;
	typedef logic [ADD_W-1:0]  add_t;
	typedef logic [CNT_W-1:0]  cnt_t;

	// One iteration per remaining bit
	localparam cnt_t CNT_START = cnt_t'(31);

	// M-extension operation groups
	typedef enum logic [1:0] {
		MD_OP_MULL = 2'd0,
		MD_OP_MULH = 2'd1,
		MD_OP_DIV  = 2'd2,
		MD_OP_REM  = 2'd3
	} md_op_e;

	// Sequencer states
	typedef enum logic [2:0] {
		MD_IDLE        = 3'd0,
		MD_ABS_A       = 3'd1,
		MD_ABS_B       = 3'd2,
		MD_COMP        = 3'd3,
		MD_LAST        = 3'd4,
		MD_CHANGE_SIGN = 3'd5,
		MD_FINISH      = 3'd6
	} md_state_e;

endpackage

`default_nettype wire
